//--- Makefile
# Verilator build and run for the mini core subsystem

VERILATOR ?= verilator
TOP       ?= tb_top
BUILD_DIR ?= build
VFLAGS    ?= --binary --assert --timescale 1ns/100ps
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f filelist.f

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
+incdir+source
source/mini_core_pkg.sv
source/core_decoder.sv
source/core_execute.sv
source/core_result.sv
source/mini_core.sv
source/mm_ram.sv
source/tb_subsystem.sv
test/tb_assertions.sv
test/tb_top.sv

//--- source/core_decoder.sv
// instruction decoder for the supported RV32I subset
// produces register indices, immediate, ALU operation and writeback source

`timescale 1ns/100ps

module core_decoder (
    input  mini_core_pkg::word_t     instr_i,
    output mini_core_pkg::reg_addr_t rs1_o,
    output mini_core_pkg::reg_addr_t rs2_o,
    output mini_core_pkg::reg_addr_t rd_o,
    output mini_core_pkg::word_t     imm_o,
    output mini_core_pkg::alu_op_e   alu_op_o,
    output logic                     use_imm_o,
    output logic                     is_load_o,
    output logic                     is_store_o,
    output logic                     is_branch_o,
    output logic                     branch_ne_o,
    output logic                     illegal_o,
    output mini_core_pkg::wb_sel_e   wb_sel_o
);
    import mini_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    wb_sel_e    wb_sel;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    always_comb begin
        imm_o       = '0;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        branch_ne_o = 1'b0;
        illegal_o   = 1'b0;
        wb_sel      = WB_NONE;
        case (opcode)
            7'b0110111: begin
                imm_o     = {instr_i[31:12], 12'b0};
                alu_op_o  = ALU_PASS_B;
                use_imm_o = 1'b1;
                wb_sel    = WB_ALU;
            end
            7'b0010011: begin
                imm_o     = {{20{instr_i[31]}}, instr_i[31:20]};
                use_imm_o = 1'b1;
                wb_sel    = WB_ALU;
                illegal_o = (funct3 != 3'b000);
            end
            7'b0110011: begin
                alu_op_o  = funct7[5] ? ALU_SUB : ALU_ADD;
                wb_sel    = WB_ALU;
                illegal_o = (funct3 != 3'b000) ||
                            (funct7 != 7'b0000000 && funct7 != 7'b0100000);
            end
            7'b0000011: begin
                imm_o     = {{20{instr_i[31]}}, instr_i[31:20]};
                use_imm_o = 1'b1;
                is_load_o = 1'b1;
                wb_sel    = WB_LOAD;
                illegal_o = (funct3 != 3'b010);
            end
            7'b0100011: begin
                imm_o      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                use_imm_o  = 1'b1;
                is_store_o = 1'b1;
                illegal_o  = (funct3 != 3'b010);
            end
            7'b1100011: begin
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
                is_branch_o = 1'b1;
                branch_ne_o = funct3[0];
                illegal_o   = (funct3[2:1] != 2'b00);
            end
            default: illegal_o = 1'b1;
        endcase
    end

    // x0 stays zero, so a write to it is dropped here
    assign wb_sel_o = (rd_o == 5'd0) ? WB_NONE : wb_sel;

endmodule

//--- source/core_execute.sv
// ALU and branch unit
// computes the arithmetic result, load/store address and next pc

`timescale 1ns/100ps

module core_execute (
    input  mini_core_pkg::word_t   pc_i,
    input  mini_core_pkg::word_t   op_a_i,
    input  mini_core_pkg::word_t   op_b_i,
    input  mini_core_pkg::word_t   imm_i,
    input  mini_core_pkg::alu_op_e alu_op_i,
    input  logic                   use_imm_i,
    input  logic                   is_branch_i,
    input  logic                   branch_ne_i,
    output mini_core_pkg::word_t   alu_result_o,
    output mini_core_pkg::word_t   next_pc_o
);
    import mini_core_pkg::*;

    word_t operand_b;
    logic  operands_equal;
    logic  branch_taken;

    assign operand_b = use_imm_i ? imm_i : op_b_i;

    // loads and stores reach here with ALU_ADD, so the sum is their address
    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_result_o = op_a_i - operand_b;
            ALU_PASS_B: alu_result_o = operand_b;
            default:    alu_result_o = op_a_i + operand_b;
        endcase
    end

    // branches always compare the two register operands
    assign operands_equal = (op_a_i == op_b_i);
    assign branch_taken   = is_branch_i && (branch_ne_i ? !operands_equal : operands_equal);

    assign next_pc_o = branch_taken ? pc_i + imm_i : pc_i + 32'd4;

endmodule

//--- source/core_result.sv
// load/store and writeback unit
// issues data bus requests and selects the register writeback value

`timescale 1ns/100ps

module core_result (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   start_i,
    input  logic                   is_load_i,
    input  logic                   is_store_i,
    input  mini_core_pkg::word_t   addr_i,
    input  mini_core_pkg::word_t   store_data_i,
    input  mini_core_pkg::word_t   alu_result_i,
    input  mini_core_pkg::wb_sel_e wb_sel_i,
    output logic                   data_req_o,
    output logic                   data_we_o,
    output mini_core_pkg::word_t   data_addr_o,
    output mini_core_pkg::word_t   data_wdata_o,
    input  logic                   data_gnt_i,
    input  logic                   data_rvalid_i,
    input  mini_core_pkg::word_t   data_rdata_i,
    output logic                   done_o,
    output logic                   wb_en_o,
    output mini_core_pkg::word_t   wb_data_o
);
    import mini_core_pkg::*;

    logic is_mem;
    logic req_pending;

    assign is_mem = is_load_i || is_store_i;

    // the request stays up until the memory grants it
    assign data_req_o = (start_i && is_mem) || req_pending;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_pending <= 1'b0;
        end else begin
            req_pending <= data_req_o && !data_gnt_i;
        end
    end

    // address and data come from held core state, so they are stable under back-pressure
    assign data_we_o    = is_store_i;
    assign data_addr_o  = addr_i;
    assign data_wdata_o = store_data_i;

    // memory instructions finish on rvalid, ALU instructions right away
    assign done_o    = is_mem ? data_rvalid_i : start_i;
    assign wb_en_o   = done_o && (wb_sel_i != WB_NONE);
    assign wb_data_o = (wb_sel_i == WB_LOAD) ? data_rdata_i : alu_result_i;

endmodule

//--- source/mini_core.sv
// multi-cycle RV32I subset core
// fetch FSM, pc, instruction register and register file
// decoder, execute and result units

`timescale 1ns/100ps

`include "mini_core_defines.svh"

module mini_core (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 fetch_enable_i,
    output logic                 instr_req_o,
    output mini_core_pkg::word_t instr_addr_o,
    input  logic                 instr_gnt_i,
    input  logic                 instr_rvalid_i,
    input  mini_core_pkg::word_t instr_rdata_i,
    output logic                 data_req_o,
    output logic                 data_we_o,
    output mini_core_pkg::word_t data_addr_o,
    output mini_core_pkg::word_t data_wdata_o,
    input  logic                 data_gnt_i,
    input  logic                 data_rvalid_i,
    input  mini_core_pkg::word_t data_rdata_i,
    output logic                 trap_o
);
    import mini_core_pkg::*;

    fetch_state_e state;
    word_t        pc;
    word_t        instr_q;
    word_t        reg_file [32];

    reg_addr_t rs1, rs2, rd;
    word_t     imm, op_a, op_b, alu_result, next_pc, wb_data;
    alu_op_e   alu_op;
    wb_sel_e   wb_sel;
    logic      use_imm, is_load, is_store, is_branch, branch_ne, illegal;
    logic      start, done, wb_en;

    // register 0 reads as zero and is never written
    assign op_a = (rs1 == 5'd0) ? '0 : reg_file[rs1];
    assign op_b = (rs2 == 5'd0) ? '0 : reg_file[rs2];

    assign start        = (state == ST_EXECUTE) && !illegal;
    assign instr_req_o  = (state == ST_FETCH);
    assign instr_addr_o = pc;
    assign trap_o       = (state == ST_TRAP);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ST_IDLE;
            pc    <= `MC_BOOT_ADDR;
        end else begin
            case (state)
                ST_IDLE:       if (fetch_enable_i) state <= ST_FETCH;
                ST_FETCH:      if (instr_gnt_i) state <= ST_WAIT_INSTR;
                ST_WAIT_INSTR: if (instr_rvalid_i) state <= ST_EXECUTE;
                ST_EXECUTE: begin
                    if (illegal) begin
                        state <= ST_TRAP;
                    end else if (is_load || is_store) begin
                        state <= ST_WAIT_DATA;
                    end else begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                ST_WAIT_DATA: begin
                    if (done) begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_TRAP;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == ST_WAIT_INSTR && instr_rvalid_i) begin
            instr_q <= instr_rdata_i;
        end
        if (wb_en) begin
            reg_file[rd] <= wb_data;
        end
    end

    core_decoder u_decoder (
        .instr_i     (instr_q),
        .rs1_o       (rs1),
        .rs2_o       (rs2),
        .rd_o        (rd),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_branch_o (is_branch),
        .branch_ne_o (branch_ne),
        .illegal_o   (illegal),
        .wb_sel_o    (wb_sel)
    );

    core_execute u_execute (
        .pc_i         (pc),
        .op_a_i       (op_a),
        .op_b_i       (op_b),
        .imm_i        (imm),
        .alu_op_i     (alu_op),
        .use_imm_i    (use_imm),
        .is_branch_i  (is_branch),
        .branch_ne_i  (branch_ne),
        .alu_result_o (alu_result),
        .next_pc_o    (next_pc)
    );

    core_result u_result (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .start_i       (start),
        .is_load_i     (is_load),
        .is_store_i    (is_store),
        .addr_i        (alu_result),
        .store_data_i  (op_b),
        .alu_result_i  (alu_result),
        .wb_sel_i      (wb_sel),
        .data_req_o    (data_req_o),
        .data_we_o     (data_we_o),
        .data_addr_o   (data_addr_o),
        .data_wdata_o  (data_wdata_o),
        .data_gnt_i    (data_gnt_i),
        .data_rvalid_i (data_rvalid_i),
        .data_rdata_i  (data_rdata_i),
        .done_o        (done),
        .wb_en_o       (wb_en),
        .wb_data_o     (wb_data)
    );

endmodule

//--- source/mini_core_defines.svh
// memory size and boot address of the mini core subsystem
// addresses of the mapped test peripherals and the pass value

`ifndef MINI_CORE_DEFINES_SVH
`define MINI_CORE_DEFINES_SVH

// byte address width of the RAM, 4 KiB
`define MC_RAM_ADDR_WIDTH 12

`define MC_BOOT_ADDR 32'h0000_0000

// test peripherals live above the RAM
`define MC_STATUS_ADDR 32'h2000_0000
`define MC_EXIT_ADDR   32'h2000_0004

`define MC_PASS_VALUE  32'd123456789

`endif

//--- source/mini_core_pkg.sv
// shared types of the mini core subsystem
// word, register index and RAM address vectors
// ALU, writeback and fetch state encodings

`include "mini_core_defines.svh"

package mini_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [`MC_RAM_ADDR_WIDTH-1:0] ram_addr_t;

    // PASS_B forwards the immediate for LUI
    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LOAD
    } wb_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WAIT_INSTR,
        ST_EXECUTE,
        ST_WAIT_DATA,
        ST_TRAP
    } fetch_state_e;

endpackage

//--- source/mm_ram.sv
// memory model with instruction and data ports
// program load port and mapped status and exit registers

`timescale 1ns/100ps

`include "mini_core_defines.svh"

module mm_ram (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     instr_req_i,
    input  mini_core_pkg::ram_addr_t instr_addr_i,
    output logic                     instr_gnt_o,
    output logic                     instr_rvalid_o,
    output mini_core_pkg::word_t     instr_rdata_o,
    input  logic                     data_req_i,
    input  logic                     data_we_i,
    input  mini_core_pkg::word_t     data_addr_i,
    input  mini_core_pkg::word_t     data_wdata_i,
    output logic                     data_gnt_o,
    output logic                     data_rvalid_o,
    output mini_core_pkg::word_t     data_rdata_o,
    input  logic                     load_valid_i,
    input  mini_core_pkg::ram_addr_t load_addr_i,
    input  mini_core_pkg::word_t     load_data_i,
    output logic                     tests_passed_o,
    output logic                     tests_failed_o,
    output logic                     exit_valid_o,
    output mini_core_pkg::word_t     exit_value_o
);
    import mini_core_pkg::*;

    localparam int unsigned WORDS = 2 ** (`MC_RAM_ADDR_WIDTH - 2);

    word_t     mem [WORDS];
    ram_addr_t data_ram_addr;
    logic      data_periph;
    logic      ram_write;
    logic      status_write;

    // the memory never stalls a request
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    assign data_ram_addr = data_addr_i[`MC_RAM_ADDR_WIDTH-1:0];
    assign data_periph   = (data_addr_i >= `MC_STATUS_ADDR);
    assign ram_write     = data_req_i && data_we_i && !data_periph;
    assign status_write  = data_req_i && data_we_i && (data_addr_i == `MC_STATUS_ADDR);

    always_ff @(posedge clk_i) begin
        if (load_valid_i) begin
            mem[load_addr_i[`MC_RAM_ADDR_WIDTH-1:2]] <= load_data_i;
        end else if (ram_write) begin
            mem[data_ram_addr[`MC_RAM_ADDR_WIDTH-1:2]] <= data_wdata_i;
        end
        instr_rdata_o <= mem[instr_addr_i[`MC_RAM_ADDR_WIDTH-1:2]];
        // peripherals read back as zero
        data_rdata_o  <= data_periph ? '0 : mem[data_ram_addr[`MC_RAM_ADDR_WIDTH-1:2]];
        if (data_req_i && data_we_i && data_addr_i == `MC_EXIT_ADDR) begin
            exit_value_o <= data_wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
            exit_valid_o   <= data_req_i && data_we_i && (data_addr_i == `MC_EXIT_ADDR);
            // the first status store decides the verdict until reset
            if (status_write && !tests_passed_o && !tests_failed_o) begin
                tests_passed_o <= (data_wdata_i == `MC_PASS_VALUE);
                tests_failed_o <= (data_wdata_i != `MC_PASS_VALUE);
            end
        end
    end

endmodule

//--- source/tb_subsystem.sv
// subsystem top level with the mini core and the memory model
// the program load port and test outputs lead out to the testbench

`timescale 1ns/100ps

`include "mini_core_defines.svh"

module tb_subsystem (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     fetch_enable_i,
    input  logic                     load_valid_i,
    input  mini_core_pkg::ram_addr_t load_addr_i,
    input  mini_core_pkg::word_t     load_data_i,
    output logic                     tests_passed_o,
    output logic                     tests_failed_o,
    output logic                     exit_valid_o,
    output logic                     trap_o,
    output mini_core_pkg::word_t     exit_value_o
);
    import mini_core_pkg::*;

    logic  instr_req, instr_gnt, instr_rvalid;
    word_t instr_addr, instr_rdata;
    logic  data_req, data_gnt, data_rvalid, data_we;
    word_t data_addr, data_wdata, data_rdata;

    mini_core u_core (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fetch_enable_i (fetch_enable_i),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata),
        .data_req_o     (data_req),
        .data_we_o      (data_we),
        .data_addr_o    (data_addr),
        .data_wdata_o   (data_wdata),
        .data_gnt_i     (data_gnt),
        .data_rvalid_i  (data_rvalid),
        .data_rdata_i   (data_rdata),
        .trap_o         (trap_o)
    );

    // only the low address bits reach the RAM on the instruction side
    mm_ram u_ram (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr[`MC_RAM_ADDR_WIDTH-1:0]),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_we_i      (data_we),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .load_valid_i   (load_valid_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

//--- test/tb_assertions.sv
// concurrent checks on the memory model
// bus rvalid timing, status outputs and the exit pulse

`timescale 1ns/100ps

module tb_assertions (
    input logic clk_i,
    input logic reset_i,
    input logic instr_req_i,
    input logic instr_gnt_i,
    input logic instr_rvalid_i,
    input logic data_req_i,
    input logic data_gnt_i,
    input logic data_rvalid_i,
    input logic tests_passed_i,
    input logic tests_failed_i,
    input logic exit_valid_i
);

    // read by the testbench at the end of the run
    int error_count = 0;

    // rvalid comes exactly one cycle after a granted request, and never otherwise
    instr_rvalid_timing: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_i == $past(instr_req_i && instr_gnt_i))
        else begin
            $error("instruction rvalid does not follow a granted request by one cycle");
            error_count = error_count + 1;
        end

    data_rvalid_timing: assert property (@(posedge clk_i) disable iff (reset_i)
        data_rvalid_i == $past(data_req_i && data_gnt_i))
        else begin
            $error("data rvalid does not follow a granted request by one cycle");
            error_count = error_count + 1;
        end

    status_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
        !(tests_passed_i && tests_failed_i))
        else begin
            $error("tests_passed and tests_failed are high together");
            error_count = error_count + 1;
        end

    exit_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        exit_valid_i |=> !exit_valid_i)
        else begin
            $error("exit_valid stayed high for more than one cycle");
            error_count = error_count + 1;
        end

endmodule

bind mm_ram tb_assertions u_assertions (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_req_i    (instr_req_i),
    .instr_gnt_i    (instr_gnt_o),
    .instr_rvalid_i (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_gnt_i     (data_gnt_o),
    .data_rvalid_i  (data_rvalid_o),
    .tests_passed_i (tests_passed_o),
    .tests_failed_i (tests_failed_o),
    .exit_valid_i   (exit_valid_o)
);

//--- test/tb_top.sv
// table-driven testbench for the mini core subsystem
// loads short RV32I programs, runs them and checks exit value and status outputs

`timescale 1ns/100ps

`include "mini_core_defines.svh"

module tb_top;

    localparam int NUM_TESTS    = 7;
    localparam int RESET_CYCLES = 5;
    // eight program words plus one guard word behind them
    localparam int LOAD_CYCLES  = 9;
    // the status and exit stores behind a trapping instruction would land inside this window
    localparam int TRAP_QUIET_CYCLES = 12;

    localparam int EXPECT_NONE = 0;
    localparam int EXPECT_PASS = 1;
    localparam int EXPECT_FAIL = 2;
    localparam int EXPECT_TRAP = 3;

    localparam logic [31:0] STATUS_ADDR = `MC_STATUS_ADDR;
    localparam logic [31:0] EXIT_ADDR   = `MC_EXIT_ADDR;
    localparam logic [31:0] PASS_VALUE  = `MC_PASS_VALUE;
    localparam logic [11:0] LOOP_COUNT  = 12'd6;

    logic                          clk;
    logic                          reset;
    logic                          fetch_enable;
    logic                          load_valid;
    logic [`MC_RAM_ADDR_WIDTH-1:0] load_addr;
    logic [31:0]                   load_data;
    logic                          tests_passed;
    logic                          tests_failed;
    logic                          exit_valid;
    logic                          trap;
    logic [31:0]                   exit_value;

    // stimulus and expected values with one row per test
    string       test_name     [NUM_TESTS];
    logic [31:0] program_words [NUM_TESTS][8];
    logic [31:0] exp_value     [NUM_TESTS];
    int          exp_status    [NUM_TESTS];
    int          instr_count   [NUM_TESTS];

    int          entry = -1;
    int          word_idx;
    logic [31:0] self_loop;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    tb_subsystem u_dut (
        .clk_i          (clk),
        .reset_i        (reset),
        .fetch_enable_i (fetch_enable),
        .load_valid_i   (load_valid),
        .load_addr_i    (load_addr),
        .load_data_i    (load_data),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .trap_o         (trap),
        .exit_value_o   (exit_value)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run took more than %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] sign_extend12(input logic [11:0] value);
        return {{20{value[11]}}, value};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // funct7 picks ADD (all zero) or SUB (bit 5 set)
    function automatic logic [31:0] encode_add_sub(input logic [6:0] funct7, input logic [4:0] rd,
                                                   input logic [4:0] rs1, input logic [4:0] rs2);
        return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] encode_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_branch(input logic ne, input logic [4:0] rs1,
                                                  input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic string status_text(input int status);
        case (status)
            EXPECT_PASS: return "pass";
            EXPECT_FAIL: return "fail";
            EXPECT_TRAP: return "trap";
            default:     return "none";
        endcase
    endfunction

    // unused program slots hold a branch to itself
    task automatic start_entry(input string name, input logic [31:0] value, input int status,
                               input int count);
        entry = entry + 1;
        test_name[entry]   = name;
        exp_value[entry]   = value;
        exp_status[entry]  = status;
        instr_count[entry] = count;
        for (int i = 0; i < 8; i++) begin
            program_words[entry][i] = self_loop;
        end
        word_idx = 0;
    endtask

    task automatic append_word(input logic [31:0] word);
        program_words[entry][word_idx] = word;
        word_idx = word_idx + 1;
    endtask

    task automatic build_table();
        logic [31:0] rand_word;
        logic [11:0] imm_a, imm_b, imm_c;
        logic [31:0] rounded;
        logic [19:0] exit_hi;

        self_loop = encode_branch(1'b0, 5'd0, 5'd0, 13'd0);
        exit_hi   = EXIT_ADDR[31:12];
        rand_word = $urandom();
        imm_a     = rand_word[11:0];
        rand_word = $urandom();
        imm_b     = rand_word[11:0];
        rand_word = $urandom();
        imm_c     = rand_word[11:0];

        start_entry("arith", sign_extend12(imm_a) + sign_extend12(imm_b) - sign_extend12(imm_c),
                    EXPECT_NONE, 7);
        append_word(encode_addi(5'd1, 5'd0, imm_a));
        append_word(encode_addi(5'd2, 5'd0, imm_b));
        append_word(encode_add_sub(7'b0000000, 5'd3, 5'd1, 5'd2));
        append_word(encode_addi(5'd5, 5'd0, imm_c));
        append_word(encode_add_sub(7'b0100000, 5'd4, 5'd3, 5'd5));
        append_word(encode_lui(5'd31, exit_hi));
        append_word(encode_sw(5'd4, 5'd31, EXIT_ADDR[11:0]));

        start_entry("lui_addi", {20'hDEADC, 12'h000} + sign_extend12(12'hEEF), EXPECT_NONE, 4);
        append_word(encode_lui(5'd1, 20'hDEADC));
        append_word(encode_addi(5'd1, 5'd1, 12'hEEF));
        append_word(encode_lui(5'd31, exit_hi));
        append_word(encode_sw(5'd1, 5'd31, EXIT_ADDR[11:0]));

        start_entry("store_load", {20'hCAFE0, 12'h000} + sign_extend12(12'h123), EXPECT_NONE, 7);
        append_word(encode_lui(5'd6, 20'hCAFE0));
        append_word(encode_addi(5'd6, 5'd6, 12'h123));
        append_word(encode_addi(5'd7, 5'd0, 12'h100));
        append_word(encode_sw(5'd6, 5'd7, 12'h000));
        append_word(encode_lw(5'd8, 5'd7, 12'h000));
        append_word(encode_lui(5'd31, exit_hi));
        append_word(encode_sw(5'd8, 5'd31, EXIT_ADDR[11:0]));

        // x2 counts up to x1 and the BEQ jumps over the ADDI of 100
        start_entry("branch_loop", {20'd0, LOOP_COUNT}, EXPECT_NONE, 2 * int'(LOOP_COUNT) + 5);
        append_word(encode_addi(5'd1, 5'd0, LOOP_COUNT));
        append_word(encode_addi(5'd2, 5'd0, 12'd0));
        append_word(encode_addi(5'd2, 5'd2, 12'd1));
        append_word(encode_branch(1'b1, 5'd2, 5'd1, 13'h1FFC));
        append_word(encode_branch(1'b0, 5'd0, 5'd0, 13'd8));
        append_word(encode_addi(5'd2, 5'd2, 12'd100));
        append_word(encode_lui(5'd31, exit_hi));
        append_word(encode_sw(5'd2, 5'd31, EXIT_ADDR[11:0]));

        // rounding the upper part makes up for the sign of the low 12 bits
        rounded = PASS_VALUE + 32'h800;
        start_entry("status_pass", 32'd0, EXPECT_PASS, 5);
        append_word(encode_lui(5'd31, STATUS_ADDR[31:12]));
        append_word(encode_lui(5'd1, rounded[31:12]));
        append_word(encode_addi(5'd1, 5'd1, PASS_VALUE[11:0]));
        append_word(encode_sw(5'd1, 5'd31, STATUS_ADDR[11:0]));
        append_word(encode_sw(5'd0, 5'd31, EXIT_ADDR[11:0]));

        start_entry("status_fail", 32'd77, EXPECT_FAIL, 4);
        append_word(encode_addi(5'd1, 5'd0, 12'd77));
        append_word(encode_lui(5'd31, STATUS_ADDR[31:12]));
        append_word(encode_sw(5'd1, 5'd31, STATUS_ADDR[11:0]));
        append_word(encode_sw(5'd1, 5'd31, EXIT_ADDR[11:0]));

        // ECALL is outside the supported subset
        // the status and exit stores behind it must never run
        start_entry("illegal", 32'd0, EXPECT_TRAP, 2);
        append_word(encode_addi(5'd1, 5'd0, 12'd1));
        append_word(32'h0000_0073);
        append_word(encode_lui(5'd31, STATUS_ADDR[31:12]));
        append_word(encode_sw(5'd1, 5'd31, STATUS_ADDR[11:0]));
        append_word(encode_sw(5'd1, 5'd31, EXIT_ADDR[11:0]));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset        = 1'b1;
        fetch_enable = 1'b0;
        load_valid   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic load_program(input int t);
        logic [31:0] byte_addr;

        for (int i = 0; i < LOAD_CYCLES; i++) begin
            byte_addr  = i * 4;
            load_valid = 1'b1;
            load_addr  = byte_addr[`MC_RAM_ADDR_WIDTH-1:0];
            load_data  = (i < 8) ? program_words[t][i] : self_loop;
            @(negedge clk);
        end
        load_valid = 1'b0;
    endtask

    task automatic run_test(input int t);
        int          errors_before;
        int          got_status;
        logic        saw_exit;
        logic [31:0] got_value;

        errors_before = error_count;
        apply_reset();
        load_program(t);
        fetch_enable = 1'b1;
        @(negedge clk);
        while (!exit_valid && !trap) begin
            @(negedge clk);
        end
        saw_exit   = exit_valid;
        got_value  = exit_value;
        got_status = trap ? EXPECT_TRAP :
                     tests_passed ? EXPECT_PASS :
                     tests_failed ? EXPECT_FAIL : EXPECT_NONE;

        check_count = check_count + 2;
        if (exp_status[t] == EXPECT_TRAP) begin
            // a trapped core must stay quiet afterwards
            check_count = check_count + 1;
            repeat (TRAP_QUIET_CYCLES) begin
                @(negedge clk);
                if (exit_valid) saw_exit = 1'b1;
            end
            if (saw_exit) begin
                $display("%s: exit was reported although the program trapped", test_name[t]);
                error_count = error_count + 1;
            end
            if (tests_passed || tests_failed) begin
                $display("%s: a status output rose although the program trapped", test_name[t]);
                error_count = error_count + 1;
            end
        end else if (got_value != exp_value[t]) begin
            $display("Fail %s: exit value expected 0x%08h, actual 0x%08h",
                     test_name[t], exp_value[t], got_value);
            error_count = error_count + 1;
        end
        if (got_status != exp_status[t]) begin
            $display("Fail %s: status expected %s, actual %s",
                     test_name[t], status_text(exp_status[t]), status_text(got_status));
            error_count = error_count + 1;
        end
        fetch_enable = 1'b0;
        if (error_count == errors_before) begin
            $display("%s: ok", test_name[t]);
        end else begin
            $display("%s: %0d errors", test_name[t], error_count - errors_before);
        end
    endtask

    initial begin
        int assert_errors;

        clk          = 1'b0;
        reset        = 1'b1;
        fetch_enable = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        void'($urandom(32'ha8f4));
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycle_limit = cycle_limit + 2 * (RESET_CYCLES + LOAD_CYCLES + 4 * instr_count[t]);
            if (exp_status[t] == EXPECT_TRAP) begin
                cycle_limit = cycle_limit + 2 * TRAP_QUIET_CYCLES;
            end
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        assert_errors = u_dut.u_ram.u_assertions.error_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion errors",
                 NUM_TESTS, check_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
